// File: logic/noc_settings.svh
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

`default_nettype none

// Flit payload width
`define NOC_DATA_WIDTH 32

// Destination and source address width
`define NOC_ADDR_WIDTH 4

// Flits held by the staging buffer and by the receive buffer
`define NOC_MAX_PACKET 16

// Length field, wide enough to count past the receive storage
`define NOC_LEN_WIDTH 6

// Entries in the link FIFO
`define NOC_FIFO_DEPTH 4

`default_nettype wire

`endif

// File: logic/noc_pkg.sv
`include "noc_settings.svh"

`default_nettype none

package noc_pkg;

    // One beat on the stream link
    // Data, end-of-packet flag, then the tdest and tid fields
    typedef struct packed {
        logic [`NOC_DATA_WIDTH-1:0] data;
        logic                       last;
        logic [`NOC_ADDR_WIDTH-1:0] dest;
        logic [`NOC_ADDR_WIDTH-1:0] src;
    } flit_t;

    // Summary of a completed packet as seen by the receiver
    typedef struct packed {
        // True flit count, saturates at the top of the field
        logic [`NOC_LEN_WIDTH-1:0]  len;
        logic [`NOC_ADDR_WIDTH-1:0] dest;
        logic [`NOC_ADDR_WIDTH-1:0] src;
        logic [`NOC_DATA_WIDTH-1:0] last_data;
        // Set when more flits arrived than the buffer holds
        logic                       truncated;
    } packet_info_t;

endpackage

`default_nettype wire

// File: logic/axis_packet_sender.sv
`timescale 1ns/1ns
`include "noc_settings.svh"

`default_nettype none

module axis_packet_sender (
    input  logic                       clk,
    input  logic                       reset,

    // Host side, single-cycle strobes
    input  logic                       write_strobe,
    input  logic [`NOC_DATA_WIDTH-1:0] write_data,
    input  logic                       send_strobe,
    input  logic [`NOC_ADDR_WIDTH-1:0] send_dest,
    input  logic [`NOC_ADDR_WIDTH-1:0] send_src,
    output logic                       sender_busy,

    // Stream master
    output logic                       m_valid,
    output noc_pkg::flit_t             m_flit,
    input  logic                       m_ready
);
    import noc_pkg::*;

    localparam int IDX_W = $clog2(`NOC_MAX_PACKET);
    localparam logic [IDX_W:0] FULL_COUNT = (IDX_W + 1)'(`NOC_MAX_PACKET);

    logic [`NOC_DATA_WIDTH-1:0] stage_mem [`NOC_MAX_PACKET];
    logic [IDX_W:0]             word_count;
    logic [IDX_W-1:0]           send_index;
    logic                       busy;
    logic [`NOC_ADDR_WIDTH-1:0] dest_q;
    logic [`NOC_ADDR_WIDTH-1:0] src_q;
    logic                       last_flit;
    logic                       accept_write;
    logic                       accept_send;
    flit_t                      out_flit;

    // Host strobes only count while idle
    assign accept_write = write_strobe && !busy && (word_count != FULL_COUNT);
    assign accept_send  = send_strobe && !busy && (word_count != '0);

    assign last_flit = ({1'b0, send_index} == (word_count - 1'b1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy       <= 1'b0;
            word_count <= '0;
            send_index <= '0;
        end else if (busy) begin
            if (m_ready) begin
                if (last_flit) begin
                    // Packet gone, staging buffer starts empty again
                    busy       <= 1'b0;
                    word_count <= '0;
                end else begin
                    send_index <= send_index + 1'b1;
                end
            end
        end else begin
            if (accept_write) begin
                word_count <= word_count + 1'b1;
            end
            if (accept_send) begin
                busy       <= 1'b1;
                send_index <= '0;
            end
        end
    end

    // Staging words and the header latched at launch
    always_ff @(posedge clk) begin
        if (accept_write) begin
            stage_mem[word_count[IDX_W-1:0]] <= write_data;
        end
        if (accept_send) begin
            dest_q <= send_dest;
            src_q  <= send_src;
        end
    end

    // Current flit comes straight from the staging slot
    always_comb begin
        out_flit.data = stage_mem[send_index];
        out_flit.last = last_flit;
        out_flit.dest = dest_q;
        out_flit.src  = src_q;
    end

    assign m_flit      = out_flit;
    assign m_valid     = busy;
    assign sender_busy = busy;

endmodule

`default_nettype wire

// File: logic/axis_link_fifo.sv
`timescale 1ns/1ns
`include "noc_settings.svh"

`default_nettype none

module axis_link_fifo (
    input  logic           clk,
    input  logic           reset,

    // Stream slave, from the sender
    input  logic           s_valid,
    input  noc_pkg::flit_t s_flit,
    output logic           s_ready,

    // Stream master, towards the receiver
    output logic           m_valid,
    output noc_pkg::flit_t m_flit,
    input  logic           m_ready
);
    import noc_pkg::*;

    localparam int PTR_W = $clog2(`NOC_FIFO_DEPTH);
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(`NOC_FIFO_DEPTH - 1);
    localparam logic [PTR_W:0]   FULL_FILL = (PTR_W + 1)'(`NOC_FIFO_DEPTH);

    flit_t            fifo_mem [`NOC_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   fill;
    logic             push;
    logic             pop;

    // Wraps at the depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_step(input logic [PTR_W-1:0] ptr);
        if (ptr == LAST_SLOT) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign s_ready = (fill != FULL_FILL);
    assign m_valid = (fill != '0);
    assign m_flit  = fifo_mem[rd_ptr];

    assign push = s_valid && s_ready;
    assign pop  = m_valid && m_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_step(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_step(rd_ptr);
            end
            // Simultaneous push and pop leaves the level alone
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= s_flit;
        end
    end

endmodule

`default_nettype wire

// File: logic/axis_packet_receiver.sv
`timescale 1ns/1ns
`include "noc_settings.svh"

`default_nettype none

module axis_packet_receiver (
    input  logic                                clk,
    input  logic                                reset,

    // Stream slave
    input  logic                                s_valid,
    input  noc_pkg::flit_t                      s_flit,
    output logic                                s_ready,

    // Host side
    input  logic                                release_strobe,
    input  logic [$clog2(`NOC_MAX_PACKET)-1:0]  read_index,
    output logic                                packet_received,
    output noc_pkg::packet_info_t               packet_info,
    output logic [`NOC_DATA_WIDTH-1:0]          read_data
);
    import noc_pkg::*;

    localparam int IDX_W = $clog2(`NOC_MAX_PACKET);
    localparam logic [`NOC_LEN_WIDTH-1:0] STORE_LIMIT = `NOC_LEN_WIDTH'(`NOC_MAX_PACKET);

    typedef enum logic [1:0] {
        IDLE,
        RECEIVE,
        HOLD
    } rx_state_t;

    rx_state_t                  state;
    logic [`NOC_DATA_WIDTH-1:0] rx_mem [`NOC_MAX_PACKET];
    logic [`NOC_LEN_WIDTH-1:0]  flit_count;
    logic [`NOC_LEN_WIDTH-1:0]  flit_num;
    logic [`NOC_LEN_WIDTH-1:0]  next_count;
    logic [`NOC_ADDR_WIDTH-1:0] rx_dest;
    logic [`NOC_ADDR_WIDTH-1:0] rx_src;
    logic [`NOC_ADDR_WIDTH-1:0] pkt_dest;
    logic [`NOC_ADDR_WIDTH-1:0] pkt_src;
    logic                       rx_accept;
    packet_info_t               info_q;

    // Stalls the link for as long as a packet is held
    assign s_ready   = (state != HOLD);
    assign rx_accept = s_valid && s_ready;

    // Position of the incoming flit within its packet
    assign flit_num   = (state == IDLE) ? '0 : flit_count;
    // Saturating, so a runaway packet still reads as long
    assign next_count = (&flit_num) ? flit_num : flit_num + 1'b1;

    // First flit carries the header straight through
    assign pkt_dest = (state == IDLE) ? s_flit.dest : rx_dest;
    assign pkt_src  = (state == IDLE) ? s_flit.src  : rx_src;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state           <= IDLE;
            flit_count      <= '0;
            packet_received <= 1'b0;
        end else begin
            packet_received <= 1'b0;
            case (state)
                IDLE, RECEIVE: begin
                    if (rx_accept) begin
                        flit_count <= next_count;
                        if (s_flit.last) begin
                            state           <= HOLD;
                            packet_received <= 1'b1;
                        end else begin
                            state <= RECEIVE;
                        end
                    end
                end
                HOLD: begin
                    if (release_strobe) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_accept) begin
            // Flits past storage are counted only
            if (flit_num < STORE_LIMIT) begin
                rx_mem[flit_num[IDX_W-1:0]] <= s_flit.data;
            end
            if (state == IDLE) begin
                rx_dest <= s_flit.dest;
                rx_src  <= s_flit.src;
            end
            if (s_flit.last) begin
                info_q.len       <= next_count;
                info_q.dest      <= pkt_dest;
                info_q.src       <= pkt_src;
                info_q.last_data <= s_flit.data;
                info_q.truncated <= (next_count > STORE_LIMIT);
            end
        end
    end

    assign packet_info = info_q;
    assign read_data   = rx_mem[read_index];

endmodule

`default_nettype wire

// File: logic/noc_endpoint_top.sv
`timescale 1ns/1ns
`include "noc_settings.svh"

`default_nettype none

module noc_endpoint_top (
    input  logic                               clk,
    input  logic                               reset,

    // Sender host port
    input  logic                               write_strobe,
    input  logic [`NOC_DATA_WIDTH-1:0]         write_data,
    input  logic                               send_strobe,
    input  logic [`NOC_ADDR_WIDTH-1:0]         send_dest,
    input  logic [`NOC_ADDR_WIDTH-1:0]         send_src,
    output logic                               sender_busy,

    // Receiver host port
    input  logic                               release_strobe,
    input  logic [$clog2(`NOC_MAX_PACKET)-1:0] read_index,
    output logic                               packet_received,
    output noc_pkg::packet_info_t              packet_info,
    output logic [`NOC_DATA_WIDTH-1:0]         read_data
);
    import noc_pkg::*;

    // Sender to FIFO
    logic  tx_valid;
    logic  tx_ready;
    flit_t tx_flit;

    // FIFO to receiver
    logic  rx_valid;
    logic  rx_ready;
    flit_t rx_flit;

    axis_packet_sender i_sender (
        .clk          (clk),
        .reset        (reset),
        .write_strobe (write_strobe),
        .write_data   (write_data),
        .send_strobe  (send_strobe),
        .send_dest    (send_dest),
        .send_src     (send_src),
        .sender_busy  (sender_busy),
        .m_valid      (tx_valid),
        .m_flit       (tx_flit),
        .m_ready      (tx_ready)
    );

    axis_link_fifo i_link (
        .clk     (clk),
        .reset   (reset),
        .s_valid (tx_valid),
        .s_flit  (tx_flit),
        .s_ready (tx_ready),
        .m_valid (rx_valid),
        .m_flit  (rx_flit),
        .m_ready (rx_ready)
    );

    axis_packet_receiver i_receiver (
        .clk             (clk),
        .reset           (reset),
        .s_valid         (rx_valid),
        .s_flit          (rx_flit),
        .s_ready         (rx_ready),
        .release_strobe  (release_strobe),
        .read_index      (read_index),
        .packet_received (packet_received),
        .packet_info     (packet_info),
        .read_data       (read_data)
    );

endmodule

`default_nettype wire

// File: bench/noc_endpoint_tb.sv
`timescale 1ns/1ns
`include "noc_settings.svh"

`default_nettype none

module noc_endpoint_tb;
    import noc_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int IDX_W      = $clog2(`NOC_MAX_PACKET);
    localparam int RX_TIMEOUT = 200;
    localparam int QUIET_SPAN = 40;

    logic                       clk;
    logic                       reset;
    logic                       write_strobe;
    logic [`NOC_DATA_WIDTH-1:0] write_data;
    logic                       send_strobe;
    logic [`NOC_ADDR_WIDTH-1:0] send_dest;
    logic [`NOC_ADDR_WIDTH-1:0] send_src;
    logic                       sender_busy;
    logic                       release_strobe;
    logic [IDX_W-1:0]           read_index;
    logic                       packet_received;
    packet_info_t               packet_info;
    logic [`NOC_DATA_WIDTH-1:0] read_data;

    logic [31:0]                lcg_state;
    // Words the receiver should hold in arrival order
    logic [`NOC_DATA_WIDTH-1:0] expected_words [$];
    int                         check_count;
    int                         error_count;
    int                         test_count;

    noc_endpoint_top i_dut (
        .clk             (clk),
        .reset           (reset),
        .write_strobe    (write_strobe),
        .write_data      (write_data),
        .send_strobe     (send_strobe),
        .send_dest       (send_dest),
        .send_src        (send_src),
        .sender_busy     (sender_busy),
        .release_strobe  (release_strobe),
        .read_index      (read_index),
        .packet_received (packet_received),
        .packet_info     (packet_info),
        .read_data       (read_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Address taken from the top LCG bits
    function automatic logic [`NOC_ADDR_WIDTH-1:0] random_addr();
        logic [31:0] value;
        value = lcg_next();
        return value[31 -: `NOC_ADDR_WIDTH];
    endfunction

    task automatic compare_value(input string name, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("[FAIL] %s %s: expected %h, actual %h", name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic require(input string name, input logic cond, input string problem);
        check_count++;
        assert (cond) else begin
            $display("%s: %s", name, problem);
            error_count++;
        end
    endtask

    task automatic stage_word(input logic [`NOC_DATA_WIDTH-1:0] word);
        @(negedge clk);
        write_strobe = 1'b1;
        write_data   = word;
        @(negedge clk);
        write_strobe = 1'b0;
    endtask

    // Staging keeps at most NOC_MAX_PACKET words and drops later writes
    task automatic stage_words(input int count);
        logic [`NOC_DATA_WIDTH-1:0] word;
        for (int i = 0; i < count; i++) begin
            word = lcg_next();
            stage_word(word);
            if (expected_words.size() < `NOC_MAX_PACKET) begin
                expected_words.push_back(word);
            end
        end
    endtask

    task automatic launch(input logic [`NOC_ADDR_WIDTH-1:0] dest,
                          input logic [`NOC_ADDR_WIDTH-1:0] src);
        @(negedge clk);
        send_strobe = 1'b1;
        send_dest   = dest;
        send_src    = src;
        @(negedge clk);
        send_strobe = 1'b0;
    endtask

    task automatic release_packet();
        @(negedge clk);
        release_strobe = 1'b1;
        @(negedge clk);
        release_strobe = 1'b0;
    endtask

    task automatic wait_received(input string name);
        int waited;
        waited = 0;
        while (!packet_received && waited < RX_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        require(name, packet_received, "timed out waiting for packet_received");
    endtask

    // Sender and receiver must both stay put for the whole span
    task automatic watch_quiet(input string name, input logic busy_expected,
                               input string problem);
        logic steady;
        steady = 1'b1;
        for (int i = 0; i < QUIET_SPAN; i++) begin
            @(negedge clk);
            if (packet_received || sender_busy !== busy_expected) begin
                steady = 1'b0;
            end
        end
        require(name, steady, problem);
    endtask

    task automatic read_stored(input logic [IDX_W-1:0] index,
                               output logic [`NOC_DATA_WIDTH-1:0] word);
        @(negedge clk);
        read_index = index;
        #(CLK_PERIOD / 4);
        word = read_data;
    endtask

    task automatic verify_packet(input string name, input logic [`NOC_ADDR_WIDTH-1:0] dest,
                                 input logic [`NOC_ADDR_WIDTH-1:0] src);
        logic [`NOC_DATA_WIDTH-1:0] word;
        compare_value(name, "length", 32'(expected_words.size()), 32'(packet_info.len));
        compare_value(name, "dest", 32'(dest), 32'(packet_info.dest));
        compare_value(name, "src", 32'(src), 32'(packet_info.src));
        compare_value(name, "last data", expected_words[$], packet_info.last_data);
        compare_value(name, "truncated", 32'd0, 32'(packet_info.truncated));
        for (int i = 0; i < expected_words.size(); i++) begin
            read_stored(IDX_W'(i), word);
            compare_value(name, $sformatf("read data %0d", i), expected_words[i], word);
        end
    endtask

    task automatic run_packet(input string name, input int count);
        logic [`NOC_ADDR_WIDTH-1:0] dest;
        logic [`NOC_ADDR_WIDTH-1:0] src;
        dest = random_addr();
        src  = random_addr();
        expected_words.delete();
        stage_words(count);
        launch(dest, src);
        wait_received(name);
        verify_packet(name, dest, src);
        release_packet();
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        $display("%s: %0d errors", name, error_count - errors_before);
    endtask

    task automatic send_single_flit();
        int errors_before;
        errors_before = error_count;
        run_packet("single_flit", 1);
        finish_test("single_flit", errors_before);
    endtask

    task automatic send_multi_flit();
        int errors_before;
        errors_before = error_count;
        run_packet("multi_flit", 7);
        finish_test("multi_flit", errors_before);
    endtask

    // Four writes past a full buffer that must not reach the packet
    task automatic fill_staging_buffer();
        int errors_before;
        errors_before = error_count;
        run_packet("full_buffer", `NOC_MAX_PACKET + 4);
        finish_test("full_buffer", errors_before);
    endtask

    task automatic hold_and_release();
        string                      name;
        int                         errors_before;
        logic [`NOC_ADDR_WIDTH-1:0] dest_a;
        logic [`NOC_ADDR_WIDTH-1:0] src_a;
        logic [`NOC_ADDR_WIDTH-1:0] dest_b;
        logic [`NOC_ADDR_WIDTH-1:0] src_b;
        logic [`NOC_DATA_WIDTH-1:0] last_a;
        name          = "hold_release";
        errors_before = error_count;
        dest_a        = random_addr();
        src_a         = random_addr();
        dest_b        = random_addr();
        src_b         = random_addr();
        expected_words.delete();
        stage_words(3);
        launch(dest_a, src_a);
        wait_received(name);
        verify_packet(name, dest_a, src_a);
        last_a = expected_words[$];
        // B is longer than the FIFO, so the sender has to stall
        expected_words.delete();
        stage_words(9);
        launch(dest_b, src_b);
        watch_quiet(name, 1'b1, "sender went idle or a packet arrived while A was held");
        compare_value(name, "held length", 32'd3, 32'(packet_info.len));
        compare_value(name, "held dest", 32'(dest_a), 32'(packet_info.dest));
        compare_value(name, "held src", 32'(src_a), 32'(packet_info.src));
        compare_value(name, "held last data", last_a, packet_info.last_data);
        release_packet();
        wait_received(name);
        verify_packet(name, dest_b, src_b);
        release_packet();
        finish_test(name, errors_before);
    endtask

    task automatic ignore_stray_strobes();
        string                      name;
        int                         errors_before;
        logic [`NOC_ADDR_WIDTH-1:0] dest;
        logic [`NOC_ADDR_WIDTH-1:0] src;
        name          = "ignored_strobes";
        errors_before = error_count;
        dest          = random_addr();
        src           = random_addr();
        expected_words.delete();
        // Empty staging buffer
        launch(dest, src);
        watch_quiet(name, 1'b0, "a send with nothing staged started a packet");
        stage_words(3);
        launch(dest, src);
        require(name, sender_busy, "sender not busy right after a send");
        // Write and send together one cycle into the transfer
        write_strobe = 1'b1;
        write_data   = lcg_next();
        send_strobe  = 1'b1;
        @(negedge clk);
        write_strobe = 1'b0;
        send_strobe  = 1'b0;
        wait_received(name);
        verify_packet(name, dest, src);
        release_packet();
        watch_quiet(name, 1'b0, "a strobe given while busy started another packet");
        run_packet(name, 2);
        finish_test(name, errors_before);
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        write_strobe   = 1'b0;
        write_data     = '0;
        send_strobe    = 1'b0;
        send_dest      = '0;
        send_src       = '0;
        release_strobe = 1'b0;
        read_index     = '0;
        lcg_state      = 32'h84d;
        check_count    = 0;
        error_count    = 0;
        test_count     = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        require("reset", !sender_busy && !packet_received, "busy or received high after reset");

        send_single_flit();
        send_multi_flit();
        fill_staging_buffer();
        hold_and_release();
        ignore_stray_strobes();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+logic
logic/noc_pkg.sv
logic/axis_packet_sender.sv
logic/axis_link_fifo.sv
logic/axis_packet_receiver.sv
logic/noc_endpoint_top.sv
bench/noc_endpoint_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= noc_endpoint_tb
BUILD_DIR ?= obj_dir
FILE_LIST ?= files.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILE_LIST)) logic/noc_settings.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)

check: run
	@grep -qx '=== PASS ===' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
